// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --top-module tb_mcbsp_transport -f sim.f

output=$(./obj_dir/Vtb_mcbsp_transport || true)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "TESTS PASSED"

// ==== sim.f ====
verilog/mcbsp_pkg.sv
verilog/axil_pkg.sv
verilog/mcbsp_word_if.sv
verilog/mcbsp_io_connect.sv
verilog/mcbsp_rx_deframer.sv
verilog/mcbsp_tx_framer.sv
verilog/mcbsp_axil_regs.sv
verilog/mcbsp_transport_top.sv
verification/mcbsp_transport_checker.sv
verification/tb_mcbsp_transport.sv

// ==== verification/mcbsp_transport_checker.sv ====
`timescale 1ns/100ps

module mcbsp_transport_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       bvalid,
    input logic       bready,
    input logic       rvalid,
    input logic       rready,
    input logic       mcbsp_fsx,
    input logic       mcbsp_frm,
    input logic [7:0] exp_n_oe
);

    // Driven bits of the N row in V2 layout
    localparam logic [7:0] N_OE_BITS = 8'b1111_1000;

    ////////////////////////////////////////////////////////////
    // AXI response hold
    ////////////////////////////////////////////////////////////

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
    else
        $error("bvalid dropped before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
    else
        $error("rvalid dropped before rready");

    ////////////////////////////////////////////////////////////
    // Pin behavior
    ////////////////////////////////////////////////////////////

    // Sync bit and data bits never overlap
    sync_vs_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !(mcbsp_fsx && mcbsp_frm))
    else
        $error("fsx and frm high together");

    n_row_oe: assert property (@(posedge clk) exp_n_oe == N_OE_BITS)
    else
        $error("exp_n_oe differs from the V2 enable pattern");

endmodule

bind mcbsp_transport_top mcbsp_transport_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .mcbsp_fsx (mcbsp_fsx),
    .mcbsp_frm (mcbsp_frm),
    .exp_n_oe  (exp_n_oe)
);

// ==== verification/tb_mcbsp_transport.sv ====
`timescale 1ns/100ps

module tb_mcbsp_transport
    import axil_pkg::*;
();

    localparam int CLK_DIV = 2;
    // Frame length in cycles with synchronizer slack
    localparam int FRAME_CYCLES = 34 * 2 * CLK_DIV + 16;
    localparam int WAIT_LIMIT = 50;
    localparam int POLL_LIMIT = 200;
    localparam logic [15:0] LFSR_SEED = 16'd13346;
    // Maximal length taps for 16 bits
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic       clk;
    logic       rst_n;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;
    logic [7:0] exp_n_in;
    logic [7:0] exp_n_out;
    logic [7:0] exp_n_oe;
    logic [7:0] exp_p_in;
    logic [7:0] exp_p_out;
    logic [7:0] exp_p_oe;

    // Words in flight with the oldest first
    logic [31:0] sent_q[$];
    logic [15:0] lfsr;
    int          errors;
    int          timeouts;

    mcbsp_transport_top #(
        .use_rp_digital_io_n (1'b1),
        .use_rp_digital_io_p (1'b1),
        .clk_div             (CLK_DIV)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .exp_n_in  (exp_n_in),
        .exp_n_out (exp_n_out),
        .exp_n_oe  (exp_n_oe),
        .exp_p_in  (exp_p_in),
        .exp_p_out (exp_p_out),
        .exp_p_oe  (exp_p_oe)
    );

    // N row loopback of clkr, fsx and tx onto the receive pins
    assign exp_n_in = {5'b00000, exp_n_out[3], exp_n_out[4], exp_n_out[6]};

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ LFSR_TAPS;
        return next;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // STATUS layout from the register map
    function automatic logic [31:0] status_word(input bit rx_held, input bit tx_free,
                                                input bit overrun);
        return {29'h0, overrun, tx_free, rx_held};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else
        begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp);
        int count;
        count = 0;
        resp  = 2'b11;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // Accept shows up as bvalid one cycle later
        do
        begin
            @(negedge clk);
            count++;
        end
        while (!bvalid && count < WAIT_LIMIT);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid)
        begin
            $display("Timeout waiting for write response at address %h", addr);
            timeouts++;
        end
        else
        begin
            resp = bresp;
            // Response held one extra cycle before it is taken
            @(negedge clk);
            bready = 1'b1;
            @(negedge clk);
            bready = 1'b0;
        end
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        int count;
        count = 0;
        data  = '0;
        resp  = 2'b11;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        do
        begin
            @(negedge clk);
            count++;
        end
        while (!rvalid && count < WAIT_LIMIT);
        arvalid = 1'b0;
        if (!rvalid)
        begin
            $display("Timeout waiting for read data at address %h", addr);
            timeouts++;
        end
        else
        begin
            data = rdata;
            resp = rresp;
            @(negedge clk);
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
        end
    endtask

    // Repeated STATUS reads until a masked bit is set
    task automatic poll_status(input axil_data_t mask, input string name,
                               output axil_data_t status);
        axil_resp_t resp;
        int         polls;
        polls  = 0;
        status = '0;
        while ((status & mask) == 0 && polls < POLL_LIMIT)
        begin
            axil_read(REG_STATUS, status, resp);
            check_equal({name, " poll resp"}, RESP_OKAY, resp);
            polls++;
        end
        if ((status & mask) == 0)
        begin
            $display("Timeout polling STATUS for %s", name);
            timeouts++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] word;
        logic [31:0] expected;
        axil_data_t  data;
        axil_resp_t  resp;
        rst_n    = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        exp_p_in = 8'h00;
        lfsr     = LFSR_SEED;
        errors   = 0;
        timeouts = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // Reset state
        check_equal("reset awready", 32'd0, awready);
        check_equal("reset wready", 32'd0, wready);
        check_equal("reset bvalid", 32'd0, bvalid);
        check_equal("reset rvalid", 32'd0, rvalid);
        // No read response pending
        check_equal("reset arready", 32'd1, arready);
        check_equal("reset exp_n_out", 32'h00, exp_n_out);
        check_equal("reset exp_n_oe", 32'hF8, exp_n_oe);
        check_equal("reset exp_p_out", 32'h00, exp_p_out);
        check_equal("reset exp_p_oe", 32'h00, exp_p_oe);
        axil_read(REG_STATUS, data, resp);
        check_equal("reset status resp", RESP_OKAY, resp);
        check_equal("reset status", status_word(0, 1, 0), data);

        // Loopback of random words
        for (int i = 0; i < 20; i++)
        begin
            word = next_random(32);
            axil_write(REG_TX_DATA, word, resp);
            check_equal("loopback write resp", RESP_OKAY, resp);
            sent_q.push_back(word);
            poll_status(32'h1, "loopback rx held", data);
            axil_read(REG_RX_DATA, data, resp);
            check_equal("loopback read resp", RESP_OKAY, resp);
            expected = sent_q.pop_front();
            check_equal("loopback word", expected, data);
        end

        // Back-pressure
        // Framer takes the first word at once and the second waits in the slot
        for (int i = 0; i < 3; i++)
        begin
            word = next_random(32);
            axil_write(REG_TX_DATA, word, resp);
            if (i < 2)
            begin
                check_equal("backpressure accept resp", RESP_OKAY, resp);
                sent_q.push_back(word);
            end
            else
                check_equal("backpressure full resp", RESP_SLVERR, resp);
        end
        for (int i = 0; i < 2; i++)
        begin
            poll_status(32'h1, "backpressure rx held", data);
            axil_read(REG_RX_DATA, data, resp);
            check_equal("backpressure read resp", RESP_OKAY, resp);
            expected = sent_q.pop_front();
            check_equal("backpressure word", expected, data);
        end
        // Refused word must never show up
        repeat (FRAME_CYCLES) @(negedge clk);
        axil_read(REG_STATUS, data, resp);
        check_equal("backpressure idle status", status_word(0, 1, 0), data);

        // Second word lost while the first is held
        for (int i = 0; i < 2; i++)
        begin
            word = next_random(32);
            axil_write(REG_TX_DATA, word, resp);
            check_equal("overrun write resp", RESP_OKAY, resp);
            sent_q.push_back(word);
        end
        poll_status(32'h4, "overrun flag", data);
        check_equal("overrun status", status_word(1, 1, 1), data);
        axil_read(REG_RX_DATA, data, resp);
        check_equal("overrun read resp", RESP_OKAY, resp);
        expected = sent_q.pop_front();
        check_equal("overrun first word", expected, data);
        expected = sent_q.pop_front();
        axil_write(REG_STATUS, next_random(32), resp);
        check_equal("overrun clear resp", RESP_OKAY, resp);
        axil_read(REG_STATUS, data, resp);
        check_equal("overrun cleared status", status_word(0, 1, 0), data);
        axil_read(REG_RX_DATA, data, resp);
        check_equal("overrun empty resp", RESP_SLVERR, resp);
        check_equal("overrun empty data", 32'h0, data);

        // Digital inputs on P row
        for (int i = 0; i < 8; i++)
        begin
            word = next_random(8);
            @(negedge clk);
            exp_p_in = word[7:0];
            // Synchronizer settling
            repeat (4) @(negedge clk);
            axil_read(REG_EXP_IN, data, resp);
            check_equal("exp_in resp", RESP_OKAY, resp);
            check_equal("exp_in byte", {24'h0, word[7:0]}, data);
        end

        // Unmapped and wrong-direction accesses
        axil_read(REG_TX_DATA, data, resp);
        check_equal("decode read tx_data resp", RESP_SLVERR, resp);
        check_equal("decode read tx_data data", 32'h0, data);
        axil_read(4'h2, data, resp);
        check_equal("decode read unaligned resp", RESP_SLVERR, resp);
        axil_write(REG_RX_DATA, next_random(32), resp);
        check_equal("decode write rx_data resp", RESP_SLVERR, resp);
        axil_write(REG_EXP_IN, next_random(32), resp);
        check_equal("decode write exp_in resp", RESP_SLVERR, resp);
        axil_write(4'h6, next_random(32), resp);
        check_equal("decode write unaligned resp", RESP_SLVERR, resp);
        axil_read(REG_STATUS, data, resp);
        check_equal("decode final status", status_word(0, 1, 0), data);

        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verilog/axil_pkg.sv ====
package axil_pkg;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite bus types
    ////////////////////////////////////////////////////////////

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Register map, byte offsets
    localparam axil_addr_t REG_STATUS  = 4'h0;
    localparam axil_addr_t REG_TX_DATA = 4'h4;
    localparam axil_addr_t REG_RX_DATA = 4'h8;
    localparam axil_addr_t REG_EXP_IN  = 4'hC;

endpackage

// ==== verilog/mcbsp_axil_regs.sv ====
`timescale 1ns/100ps

module mcbsp_axil_regs
    import mcbsp_pkg::*, axil_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [7:0]       exp_in,
    // Write address and data
    input  axil_addr_t       awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  axil_data_t       wdata,
    input  logic             wvalid,
    output logic             wready,
    // Write response
    output axil_resp_t       bresp,
    output logic             bvalid,
    input  logic             bready,
    // Read address
    input  axil_addr_t       araddr,
    input  logic             arvalid,
    output logic             arready,
    // Read data
    output axil_data_t       rdata,
    output axil_resp_t       rresp,
    output logic             rvalid,
    input  logic             rready,
    mcbsp_word_if.consumer   rx_words,
    mcbsp_word_if.producer   tx_words
);

    logic        wr_accept;
    logic        rd_accept;
    logic        tx_valid;
    mcbsp_word_t tx_word;
    axil_data_t  status;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    // Address and data taken together, stalled by pending response
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign arready   = !rvalid;
    assign rd_accept = arvalid && arready;

    // Pop held rx word on a successful read
    assign rx_words.ready = rd_accept && (araddr == REG_RX_DATA) && rx_words.valid;
    // Any write to status clears overrun
    assign rx_words.clear = wr_accept && (awaddr == REG_STATUS);

    // Bit 0 rx held, bit 1 tx free, bit 2 overrun
    assign status = {29'h0, rx_words.overrun, !tx_valid, rx_words.valid};

    assign tx_words.word  = tx_word;
    assign tx_words.valid = tx_valid;

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
            tx_valid <= 1'b0;
        end
        else
        begin
            if (bvalid && bready)
                bvalid <= 1'b0;
            // Slot frees when the framer takes the word
            if (tx_valid && tx_words.ready)
                tx_valid <= 1'b0;
            if (wr_accept)
            begin
                bvalid <= 1'b1;
                case (awaddr)
                    REG_STATUS:
                        bresp <= RESP_OKAY;
                    REG_TX_DATA:
                    begin
                        if (!tx_valid)
                        begin
                            tx_valid <= 1'b1;
                            bresp    <= RESP_OKAY;
                        end
                        else
                            bresp <= RESP_SLVERR;
                    end
                    default:
                        bresp <= RESP_SLVERR;
                endcase
            end
        end
    end

    // Word only stored when the slot is free
    always_ff @(posedge clk)
    begin
        if (wr_accept && (awaddr == REG_TX_DATA) && !tx_valid)
            tx_word <= wdata;
    end

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
        end
        else
        begin
            if (rvalid && rready)
                rvalid <= 1'b0;
            if (rd_accept)
            begin
                rvalid <= 1'b1;
                case (araddr)
                    REG_STATUS, REG_EXP_IN:
                        rresp <= RESP_OKAY;
                    REG_RX_DATA:
                        rresp <= rx_words.valid ? RESP_OKAY : RESP_SLVERR;
                    default:
                        rresp <= RESP_SLVERR;
                endcase
            end
        end
    end

    // Read data, zero on errors
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            case (araddr)
                REG_STATUS:  rdata <= status;
                REG_RX_DATA: rdata <= rx_words.valid ? rx_words.word : '0;
                REG_EXP_IN:  rdata <= {24'h0, exp_in};
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/mcbsp_io_connect.sv ====
`timescale 1ns/100ps

module mcbsp_io_connect #(
    parameter bit use_rp_digital_io_n = 1'b0,
    parameter bit use_rp_digital_io_p = 1'b0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] exp_n_in,
    input  logic [7:0] exp_p_in,
    input  logic       mcbsp_clkr,
    input  logic       mcbsp_tx,
    input  logic       mcbsp_fsx,
    input  logic       mcbsp_frm,
    output logic [7:0] exp_n_out,
    output logic [7:0] exp_n_oe,
    output logic [7:0] exp_p_out,
    output logic [7:0] exp_p_oe,
    output logic       mcbsp_clk,
    output logic       mcbsp_fs,
    output logic       mcbsp_rx,
    output logic [7:0] exp_in
);

    // N row drives bits 3 to 7, bits 0 to 2 are inputs
    localparam logic [7:0] N_OE_MASK = 8'hF8;

    logic [2:0]  n_raw;
    logic [7:0]  p_raw;
    logic [10:0] sync_q1;
    logic [10:0] sync_q2;

    // Unused rows read as zero
    assign n_raw = use_rp_digital_io_n ? exp_n_in[2:0] : 3'b000;
    assign p_raw = use_rp_digital_io_p ? exp_p_in : 8'h00;

    // Two-flop synchronizer, all inputs together
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end
        else
        begin
            sync_q1 <= {p_raw, n_raw};
            sync_q2 <= sync_q1;
        end
    end

    // Received McBSP signals
    assign mcbsp_clk = sync_q2[0];
    assign mcbsp_fs  = sync_q2[1];
    assign mcbsp_rx  = sync_q2[2];
    // General input byte from P row
    assign exp_in    = sync_q2[10:3];

    // V2 layout: tx, fsx, frm, clkr, then forwarded rx held low
    assign exp_n_out = use_rp_digital_io_n ?
                       {1'b0, mcbsp_clkr, mcbsp_frm, mcbsp_fsx, mcbsp_tx, 3'b000} : 8'h00;
    assign exp_n_oe  = use_rp_digital_io_n ? N_OE_MASK : 8'h00;

    // P row is input only
    assign exp_p_out = 8'h00;
    assign exp_p_oe  = 8'h00;

endmodule

// ==== verilog/mcbsp_pkg.sv ====
package mcbsp_pkg;

    ////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////

    // One word per frame, fixed length
    localparam int WORD_BITS = 32;

    // Payload of one frame
    typedef logic [WORD_BITS-1:0] mcbsp_word_t;

    // Bit position inside a frame
    typedef logic [$clog2(WORD_BITS)-1:0] bit_cnt_t;

    // Transmit framer states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SYNC,
        TX_SHIFT,
        TX_GAP
    } tx_state_t;

endpackage

// ==== verilog/mcbsp_rx_deframer.sv ====
`timescale 1ns/100ps

module mcbsp_rx_deframer
    import mcbsp_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mcbsp_clk,
    input  logic             mcbsp_fs,
    input  logic             mcbsp_rx,
    mcbsp_word_if.producer   rx_words
);

    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(WORD_BITS - 1);

    logic        clk_q;
    logic        rise;
    logic        armed;
    logic        done;
    bit_cnt_t    bit_cnt;
    mcbsp_word_t shift_reg;
    mcbsp_word_t word_q;
    logic        valid_q;
    logic        overrun_q;
    logic        drop;

    // Rising edge of synchronized bit clock
    assign rise = mcbsp_clk && !clk_q;

    ////////////////////////////////////////////////////////////
    // Frame tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            clk_q   <= 1'b0;
            armed   <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            clk_q <= mcbsp_clk;
            done  <= 1'b0;
            if (rise)
            begin
                if (!armed)
                begin
                    // Frame sync seen on a clock edge
                    armed   <= mcbsp_fs;
                    bit_cnt <= '0;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == LAST_BIT)
                    begin
                        armed <= 1'b0;
                        done  <= 1'b1;
                    end
                end
            end
        end
    end

    // MSB first into the shifter
    always_ff @(posedge clk)
    begin
        if (rise && armed)
            shift_reg <= {shift_reg[WORD_BITS-2:0], mcbsp_rx};
    end

    ////////////////////////////////////////////////////////////
    // Word hand-off
    ////////////////////////////////////////////////////////////

    // Previous word still waiting
    assign drop = valid_q && !rx_words.ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q   <= 1'b0;
            overrun_q <= 1'b0;
        end
        else
        begin
            if (valid_q && rx_words.ready)
                valid_q <= 1'b0;
            if (rx_words.clear)
                overrun_q <= 1'b0;
            // New word lost, sticky flag
            if (done && drop)
                overrun_q <= 1'b1;
            else if (done)
                valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (done && !drop)
            word_q <= shift_reg;
    end

    assign rx_words.word    = word_q;
    assign rx_words.valid   = valid_q;
    assign rx_words.overrun = overrun_q;

endmodule

// ==== verilog/mcbsp_transport_top.sv ====
`timescale 1ns/100ps

module mcbsp_transport_top
    import axil_pkg::*;
#(
    parameter bit use_rp_digital_io_n = 1'b1,
    parameter bit use_rp_digital_io_p = 1'b1,
    parameter int clk_div             = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    // AXI4-Lite slave
    input  axil_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axil_data_t wdata,
    input  logic       wvalid,
    output logic       wready,
    output axil_resp_t bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output axil_data_t rdata,
    output axil_resp_t rresp,
    output logic       rvalid,
    input  logic       rready,
    // Expansion connector rows
    input  logic [7:0] exp_n_in,
    output logic [7:0] exp_n_out,
    output logic [7:0] exp_n_oe,
    input  logic [7:0] exp_p_in,
    output logic [7:0] exp_p_out,
    output logic [7:0] exp_p_oe
);

    logic       mcbsp_clk;
    logic       mcbsp_fs;
    logic       mcbsp_rx;
    logic       mcbsp_clkr;
    logic       mcbsp_tx;
    logic       mcbsp_fsx;
    logic       mcbsp_frm;
    logic [7:0] exp_in;

    mcbsp_word_if rx_words ();
    mcbsp_word_if tx_words ();

    // Transmit path has no loss condition
    assign tx_words.overrun = 1'b0;

    mcbsp_io_connect #(
        .use_rp_digital_io_n (use_rp_digital_io_n),
        .use_rp_digital_io_p (use_rp_digital_io_p)
    ) u_io_connect (
        .clk        (clk),
        .rst_n      (rst_n),
        .exp_n_in   (exp_n_in),
        .exp_p_in   (exp_p_in),
        .mcbsp_clkr (mcbsp_clkr),
        .mcbsp_tx   (mcbsp_tx),
        .mcbsp_fsx  (mcbsp_fsx),
        .mcbsp_frm  (mcbsp_frm),
        .exp_n_out  (exp_n_out),
        .exp_n_oe   (exp_n_oe),
        .exp_p_out  (exp_p_out),
        .exp_p_oe   (exp_p_oe),
        .mcbsp_clk  (mcbsp_clk),
        .mcbsp_fs   (mcbsp_fs),
        .mcbsp_rx   (mcbsp_rx),
        .exp_in     (exp_in)
    );

    mcbsp_rx_deframer u_rx_deframer (
        .clk       (clk),
        .rst_n     (rst_n),
        .mcbsp_clk (mcbsp_clk),
        .mcbsp_fs  (mcbsp_fs),
        .mcbsp_rx  (mcbsp_rx),
        .rx_words  (rx_words.producer)
    );

    mcbsp_tx_framer #(
        .clk_div (clk_div)
    ) u_tx_framer (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_words   (tx_words.consumer),
        .mcbsp_clkr (mcbsp_clkr),
        .mcbsp_tx   (mcbsp_tx),
        .mcbsp_fsx  (mcbsp_fsx),
        .mcbsp_frm  (mcbsp_frm)
    );

    mcbsp_axil_regs u_axil_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .exp_in   (exp_in),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .rx_words (rx_words.consumer),
        .tx_words (tx_words.producer)
    );

endmodule

// ==== verilog/mcbsp_tx_framer.sv ====
`timescale 1ns/100ps

module mcbsp_tx_framer
    import mcbsp_pkg::*;
#(
    parameter int clk_div = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    mcbsp_word_if.consumer   tx_words,
    output logic             mcbsp_clkr,
    output logic             mcbsp_tx,
    output logic             mcbsp_fsx,
    output logic             mcbsp_frm
);

    // Bit period is two half periods of clk_div cycles
    localparam int DIV_W = $clog2(2 * clk_div);
    localparam logic [DIV_W-1:0] HALF_END = DIV_W'(clk_div - 1);
    localparam logic [DIV_W-1:0] BIT_END  = DIV_W'(2 * clk_div - 1);
    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(WORD_BITS - 1);

    tx_state_t        state;
    logic [DIV_W-1:0] div_cnt;
    bit_cnt_t         bit_cnt;
    mcbsp_word_t      shift_reg;
    logic             period_end;

    assign period_end = (state != TX_IDLE) && (div_cnt == BIT_END);

    // Words only taken between frames
    assign tx_words.ready = (state == TX_IDLE);
    // Nothing to clear on the transmit side
    assign tx_words.clear = 1'b0;

    ////////////////////////////////////////////////////////////
    // Framer FSM and bit clock
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= TX_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            mcbsp_clkr <= 1'b0;
            mcbsp_tx   <= 1'b0;
            mcbsp_fsx  <= 1'b0;
            mcbsp_frm  <= 1'b0;
        end
        else if (state == TX_IDLE)
        begin
            if (tx_words.valid)
            begin
                state     <= TX_SYNC;
                mcbsp_fsx <= 1'b1;
                div_cnt   <= '0;
                bit_cnt   <= '0;
            end
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            // Rising clkr mid-period, data is stable here
            if (div_cnt == HALF_END)
                mcbsp_clkr <= 1'b1;
            if (period_end)
            begin
                div_cnt    <= '0;
                mcbsp_clkr <= 1'b0;
                case (state)
                    TX_SYNC:
                    begin
                        state     <= TX_SHIFT;
                        mcbsp_fsx <= 1'b0;
                        mcbsp_frm <= 1'b1;
                        mcbsp_tx  <= shift_reg[WORD_BITS-1];
                    end
                    TX_SHIFT:
                    begin
                        if (bit_cnt == LAST_BIT)
                        begin
                            // Last bit done, one idle period follows
                            state     <= TX_GAP;
                            mcbsp_frm <= 1'b0;
                            mcbsp_tx  <= 1'b0;
                        end
                        else
                        begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            mcbsp_tx <= shift_reg[WORD_BITS-1];
                        end
                    end
                    default:
                        state <= TX_IDLE;
                endcase
            end
        end
    end

    // Load on accept, shift at each bit boundary
    always_ff @(posedge clk)
    begin
        if (tx_words.valid && tx_words.ready)
            shift_reg <= tx_words.word;
        else if (period_end && (state == TX_SYNC || state == TX_SHIFT))
            shift_reg <= {shift_reg[WORD_BITS-2:0], 1'b0};
    end

endmodule

// ==== verilog/mcbsp_word_if.sv ====
`timescale 1ns/100ps

interface mcbsp_word_if
    import mcbsp_pkg::*;
();

    // Word stream with valid/ready handshake
    mcbsp_word_t word;
    logic        valid;
    logic        ready;
    // Sticky loss flag and its clear pulse
    logic        overrun;
    logic        clear;

    modport producer (output word, output valid, output overrun, input ready, input clear);

    modport consumer (input word, input valid, input overrun, output ready, output clear);

endinterface
